// File: include/mini_cpu_config.svh
`ifndef MINI_CPU_CONFIG_SVH
`define MINI_CPU_CONFIG_SVH

// core-wide constants for mini_cpu

// fetch starts from next pc, so the first pc sits one word below zero
`define MINI_CPU_RESET_ADDR 32'hffff_fffc

// class misc with every other field clear, executes as a no-op
`define MINI_CPU_NOP 32'hc000_0000

// nops issued after run drops, before stopped is raised
`define MINI_CPU_STOP_FLUSH 2

// instruction memory depth in words
`define MINI_CPU_IMEM_WORDS 64

// data memory depth in words
`define MINI_CPU_DMEM_WORDS 16

// architectural registers, r0 reads as zero
`define MINI_CPU_NREGS 8

`endif

// File: mini_cpu.f
+incdir+include
verilog/mini_cpu_pkg.sv
verilog/fetch_unit.sv
verilog/instr_rom.sv
verilog/exec_unit.sv
verilog/debug_ctrl.sv
verilog/mini_cpu_top.sv
sim/mini_cpu_props.sv
sim/mini_cpu_tb.sv

// File: sim/mini_cpu_patterns.hex
// load: word address, instruction word
// command: cmd (0 halt 1 resume 2 read_pc 3 write_pc 4 read_reg), reg or data, exp data, exp err
00 32001234  // lui  r1, 0x1234
01 02405678  // addi r1, r1, 0x5678
02 04000004  // addi r2, r0, 4
03 50880008  // st   r1, [r2 + 8]
04 46800008  // ld   r3, [r2 + 8]
05 80000001  // br   +1, skips word 6
06 080000ff  // addi r4, r0, 0xff  never runs
07 0a00ffff  // addi r5, r0, -1
08 91400001  // beqz r5, +1  falls through
09 2c680000  // xor  r6, r1, r5
0a 91000001  // beqz r4, +1  taken
0b 08000055  // addi r4, r0, 0x55  never runs
0c 1ed00000  // add  r7, r3, r2
0d 8000ffff  // br   -1, parks at 0x34
2 00000000 fffffffc 0  // read_pc after reset
0 00000000 fffffffc 0  // halt while halted
2 00000000 fffffffc 0
3 00000000 00000000 0  // write_pc 0
1 00000000 00000000 0  // resume reports pc
3 00000010 00000000 1  // refused while running
4 00000001 00000000 1
3 00000020 00000000 1
4 00000007 00000000 1
4 00000003 00000000 1
0 00000000 00000034 0  // halt on the branch-to-self
2 00000000 00000034 0
4 00000000 00000000 0
4 00000001 12345678 0
4 00000002 00000004 0
4 00000003 12345678 0  // loaded back from data memory
4 00000004 00000000 0  // written only in skipped words
4 00000005 ffffffff 0
4 00000006 edcba987 0
4 00000007 1234567c 0

// File: sim/mini_cpu_props.sv
`timescale 1ns/1ps
`include "mini_cpu_config.svh"

module mini_cpu_props (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   dbg_req,
  input logic                   dbg_ack,
  input mini_cpu_pkg::dbg_rsp_t dbg_rsp,
  input logic                   stall_clear,
  input mini_cpu_pkg::instr_t   instr,
  input logic                   stopped,
  input logic [31:0]            fetch_addr,
  input logic                   dbg_pc_wr_en
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // four-phase debug handshake

  ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(dbg_ack) |-> dbg_req)
    else $error("dbg_ack rose while dbg_req was low");

  ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(dbg_ack) |-> !$past(dbg_req))
    else $error("dbg_ack dropped before dbg_req was released");

  rsp_hold_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
    dbg_ack && $past(dbg_ack) |-> $stable(dbg_rsp))
    else $error("dbg_rsp changed while dbg_ack was high");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stall protocol and stopped core

  // the clear lands while fetch is sending stall nops and lasts one cycle
  clear_inside_stall: assert property (@(posedge clk) disable iff (!rst_n)
    stall_clear |-> (instr == mini_cpu_pkg::instr_t'(`MINI_CPU_NOP)) ##1 !stall_clear)
    else $error("stall_clear pulsed outside a stall or for more than one cycle");

  // a debug pc write is the only thing that may move a stopped fetch
  addr_still_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
    stopped && $past(stopped) && !dbg_pc_wr_en |-> $stable(fetch_addr))
    else $error("fetch_addr moved while the core was stopped");

endmodule

// File: sim/mini_cpu_tb.sv
`timescale 1ns/1ps

module mini_cpu_tb;

  localparam string PATTERN_FILE = "sim/mini_cpu_patterns.hex";
  localparam int    CYCLES_PER_RECORD = 200;  // handshake budget per record
  localparam int    CLK_PERIOD = 100;

  logic                     clk;
  logic                     rst_n;
  mini_cpu_pkg::imem_load_t load;
  logic                     dbg_req;
  mini_cpu_pkg::dbg_cmd_t   dbg_cmd;
  logic                     dbg_ack;
  mini_cpu_pkg::dbg_rsp_t   dbg_rsp;

  logic [5:0]               prog_addr [$];  // program image from the pattern file
  logic [31:0]              prog_word [$];
  mini_cpu_pkg::dbg_cmd_t   cmd_list [$];   // host commands, in order
  mini_cpu_pkg::dbg_rsp_t   exp_list [$];   // expected answer per command
  int                       n_records = 0;
  int                       fail_count = 0;

  mini_cpu_top uut (
    .clk, .rst_n, .load, .dbg_req, .dbg_cmd, .dbg_ack, .dbg_rsp
  );

  bind mini_cpu_top mini_cpu_props u_props (
    .clk, .rst_n, .dbg_req, .dbg_ack, .dbg_rsp, .stall_clear, .instr, .stopped,
    .fetch_addr, .dbg_pc_wr_en
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;  // 100 ns period

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // failure reporting and compares

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_rsp(input mini_cpu_pkg::dbg_rsp_t got,
                           input mini_cpu_pkg::dbg_rsp_t exp, input string name);
    if (got !== exp) begin
      fail_count++;
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      fail_count++;
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pattern reader, two columns load a word and four columns are a command

  task automatic read_patterns();
    int                     fd;
    int                     n;
    string                  line;
    logic [31:0]            f0, f1, f2, f3;
    mini_cpu_pkg::dbg_cmd_t c;
    mini_cpu_pkg::dbg_rsp_t r;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the pattern file %s", PATTERN_FILE);
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h %h", f0, f1, f2, f3);
      if (n == 2) begin
        prog_addr.push_back(f0[5:0]);
        prog_word.push_back(f1);
      end else if (n == 4) begin
        c.cmd     = mini_cpu_pkg::dbg_cmd_e'(f0[2:0]);
        c.reg_idx = f1[2:0];  // read_reg index
        c.data    = f1;       // write_pc value
        r.err     = f3[0];
        r.data    = f2;
        cmd_list.push_back(c);
        exp_list.push_back(r);
      end
    end
    $fclose(fd);
    if (cmd_list.size() == 0) begin
      $display("the pattern file holds no command records");
      abort_run();
    end
    n_records = prog_word.size() + cmd_list.size();
  endtask

  // one full four-phase transfer, response sampled mid-cycle
  task automatic run_command(input mini_cpu_pkg::dbg_cmd_t c,
                             input mini_cpu_pkg::dbg_rsp_t exp);
    mini_cpu_pkg::dbg_rsp_t got;
    @(negedge clk);
    check_bit(dbg_ack, 1'b0, "dbg_ack");  // previous transfer fully closed
    @(posedge clk);
    dbg_cmd <= c;
    dbg_req <= 1'b1;
    @(negedge clk);
    while (!dbg_ack)
      @(negedge clk);
    got = dbg_rsp;
    check_bit(got.err, exp.err, "dbg_rsp.err");
    check_rsp(got, exp, "dbg_rsp");
    @(posedge clk);
    dbg_req <= 1'b0;
    @(negedge clk);
    while (dbg_ack)
      @(negedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // watchdog, scaled by the pattern length

  initial begin
    wait (n_records > 0);
    #(n_records * CYCLES_PER_RECORD * CLK_PERIOD);
    $display("timeout: the debug handshake hung, dbg_ack never completed");
    abort_run();
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst_n   = 1'b0;
    load    = '0;
    dbg_req = 1'b0;
    dbg_cmd = '0;
    read_patterns();
    repeat (5) @(posedge clk);  // reset held 5 cycles
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit(dbg_ack, 1'b0, "dbg_ack");
    // program goes in while the core is halted
    for (int i = 0; i < prog_word.size(); i++) begin
      @(posedge clk);
      load <= {1'b1, prog_addr[i], prog_word[i]};
    end
    @(posedge clk);
    load <= '0;
    for (int i = 0; i < cmd_list.size(); i++)
      run_command(cmd_list[i], exp_list[i]);
    if (fail_count == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// File: verilog/debug_ctrl.sv
`timescale 1ns/1ps

module debug_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dbg_req,
  input  mini_cpu_pkg::dbg_cmd_t dbg_cmd,
  input  logic                   stopped,
  input  logic [31:0]            dbg_pc,
  input  logic [31:0]            dbg_reg_val,
  output logic                   dbg_ack,
  output mini_cpu_pkg::dbg_rsp_t dbg_rsp,
  output logic                   run,
  output logic                   dbg_pc_wr_en,
  output logic [31:0]            dbg_pc_wr_val,
  output logic [2:0]             dbg_reg_sel
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_WAIT_STOP,
    ST_ACK
  } state_e;

  state_e                 state;
  mini_cpu_pkg::dbg_cmd_t cmd_q;  // command held for the whole transfer
  logic                   busy;   // core not fully stopped

  assign busy          = run || !stopped;
  assign dbg_ack       = state == ST_ACK;
  assign dbg_reg_sel   = cmd_q.reg_idx;
  assign dbg_pc_wr_val = cmd_q.data;
  // single-cycle pulse, refused while running
  assign dbg_pc_wr_en  = state == ST_EXEC && !busy &&
                         cmd_q.cmd == mini_cpu_pkg::DBG_WRITE_PC;

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && dbg_req)
      cmd_q <= dbg_cmd;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // four-phase handshake FSM, response written once per command

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      run     <= 1'b0;   // halted until resume
      dbg_rsp <= '0;
    end else begin
      case (state)
        ST_IDLE: if (dbg_req) state <= ST_EXEC;
        ST_EXEC: begin
          state <= ST_ACK;
          case (cmd_q.cmd)
            mini_cpu_pkg::DBG_HALT: begin
              run   <= 1'b0;
              state <= ST_WAIT_STOP;  // response once drained
            end
            mini_cpu_pkg::DBG_RESUME:   dbg_rsp <= {1'b0, dbg_pc};
            mini_cpu_pkg::DBG_READ_PC:  dbg_rsp <= {1'b0, dbg_pc};
            mini_cpu_pkg::DBG_WRITE_PC: dbg_rsp <= {busy, busy ? 32'd0 : cmd_q.data};
            mini_cpu_pkg::DBG_READ_REG: dbg_rsp <= {busy, busy ? 32'd0 : dbg_reg_val};
            default:                    dbg_rsp <= {1'b1, 32'd0};  // unknown command
          endcase
          if (cmd_q.cmd == mini_cpu_pkg::DBG_RESUME)
            run <= 1'b1;
        end
        ST_WAIT_STOP: if (stopped) begin
          dbg_rsp <= {1'b0, dbg_pc};  // pc where the core parked
          state   <= ST_ACK;
        end
        default: if (!dbg_req) state <= ST_IDLE;  // ack drops next cycle
      endcase
    end
  end

endmodule

// File: verilog/exec_unit.sv
`timescale 1ns/1ps
`include "mini_cpu_config.svh"

module exec_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mini_cpu_pkg::instr_t instr,
  input  logic [31:0]          pc_plus_4,
  input  logic [2:0]           dbg_reg_sel,
  output logic                 branch_taken,
  output logic [31:0]          branch_pc,
  output logic                 stall_clear,
  output logic [31:0]          dbg_reg_val
);

  localparam int DMEM_AW = $clog2(`MINI_CPU_DMEM_WORDS);

  mini_cpu_pkg::instr_t ir;      // instruction being executed
  logic [31:0]          ir_pc4;  // its pc plus 4

  logic [31:0]          regs [`MINI_CPU_NREGS];
  logic [31:0]          dmem [`MINI_CPU_DMEM_WORDS];

  logic [31:0]          op_a;
  logic [31:0]          op_b;
  logic [31:0]          imm_sx;
  logic [31:0]          alu_res;
  logic [31:0]          mem_addr;
  logic                 alu_wr;
  logic                 mem_start;

  logic                 mem_phase;  // access cycle, clears the stall
  logic                 mem_load;
  logic [2:0]           mem_rd;
  logic [DMEM_AW-1:0]   mem_idx;
  logic [31:0]          mem_rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      ir <= mini_cpu_pkg::instr_t'(`MINI_CPU_NOP);
    else
      ir <= instr;
  end

  always_ff @(posedge clk) begin
    ir_pc4 <= pc_plus_4;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // operands and ALU

  assign op_a   = (ir.ra == 3'd0) ? 32'd0 : regs[ir.ra];  // r0 is zero
  assign op_b   = (ir.rb == 3'd0) ? 32'd0 : regs[ir.rb];
  assign imm_sx = {{16{ir.imm[15]}}, ir.imm};

  always_comb begin
    case (mini_cpu_pkg::alu_op_e'(ir.op))
      mini_cpu_pkg::ALU_ADDI: alu_res = op_a + imm_sx;
      mini_cpu_pkg::ALU_ADD:  alu_res = op_a + op_b;
      mini_cpu_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
      default:                alu_res = {ir.imm, 16'h0000};  // lui
    endcase
  end

  assign alu_wr    = ir.cls == mini_cpu_pkg::CLS_ALU && ir.rd != 3'd0;
  assign mem_start = ir.cls == mini_cpu_pkg::CLS_MEM;
  assign mem_addr  = op_a + imm_sx;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // branches resolve in the execute cycle

  assign branch_taken = ir.cls == mini_cpu_pkg::CLS_BRANCH &&
                        (ir.op == 2'd0 || (ir.op == 2'd1 && op_a == 32'd0));
  assign branch_pc    = ir_pc4 + {imm_sx[29:0], 2'b00};  // word offset
  assign stall_clear  = ir.cls == mini_cpu_pkg::CLS_BRANCH || mem_phase;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // data memory, one extra cycle before stall_clear

  // fetch sends nops while stalled, so ir is a nop during mem_phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      mem_phase <= 1'b0;
    else
      mem_phase <= mem_start;
  end

  always_ff @(posedge clk) begin
    if (mem_start) begin
      mem_load <= ir.op == 2'd0;
      mem_rd   <= ir.rd;
      mem_idx  <= mem_addr[DMEM_AW+1:2];
    end
    if (mem_start && ir.op == 2'd1)
      dmem[mem_addr[DMEM_AW+1:2]] <= op_b;  // store rb
  end

  assign mem_rdata = dmem[mem_idx];

  // register file, single write port shared by ALU and load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `MINI_CPU_NREGS; i++)
        regs[i] <= 32'd0;
    end else if (alu_wr) begin
      regs[ir.rd] <= alu_res;
    end else if (mem_phase && mem_load && mem_rd != 3'd0) begin
      regs[mem_rd] <= mem_rdata;
    end
  end

  assign dbg_reg_val = (dbg_reg_sel == 3'd0) ? 32'd0 : regs[dbg_reg_sel];

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "mini_cpu_config.svh"

module fetch_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall_clear,
  input  logic                 branch_taken,
  input  logic [31:0]          branch_pc,
  input  logic [31:0]          fetch_data,
  input  logic                 run,
  input  logic                 dbg_pc_wr_en,
  input  logic [31:0]          dbg_pc_wr_val,
  output mini_cpu_pkg::instr_t instr,
  output logic [31:0]          pc_plus_4,
  output logic [31:0]          fetch_addr,
  output logic                 stopped,
  output logic [31:0]          dbg_pc
);

  localparam int CTR_W = $clog2(`MINI_CPU_STOP_FLUSH + 1);

  logic [31:0]          pc;           // address of the word on fetch_data
  logic [31:0]          next_pc;
  mini_cpu_pkg::instr_t fetch_word;   // rom word viewed as fields
  logic                 stall_start;  // mem/branch word being presented now
  logic                 stalling;
  logic                 stalled;      // nops go out while set
  logic                 stopping;     // draining or halted
  logic                 advance;      // pc moves on this edge
  logic [CTR_W-1:0]     stop_ctr;

  assign fetch_word = fetch_data;
  assign pc_plus_4  = pc + 32'd4;  // branch offsets are relative to this
  assign dbg_pc     = pc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stall detection, partial decode of the class field only

  assign stall_start = !stalled && !stopping &&
                       (fetch_word.cls == mini_cpu_pkg::CLS_MEM ||
                        fetch_word.cls == mini_cpu_pkg::CLS_BRANCH);
  assign stalling    = (stall_start || stalled) && !stall_clear;
  assign advance     = !stalling && !stopping;

  // the stalling word itself goes out, the re-fetched copies do not
  assign instr = (stalled || stopping) ? mini_cpu_pkg::instr_t'(`MINI_CPU_NOP) : fetch_word;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next pc, debug write beats branch beats sequential

  always_comb begin
    if (dbg_pc_wr_en)
      next_pc = dbg_pc_wr_val;
    else if (branch_taken)
      next_pc = branch_pc;
    else
      next_pc = pc_plus_4;
  end

  // hold the rom on pc while stalling, stopping or halted
  assign fetch_addr = (dbg_pc_wr_en || (advance && run)) ? next_pc : pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `MINI_CPU_RESET_ADDR;
    end else if (dbg_pc_wr_en) begin
      pc <= dbg_pc_wr_val;   // only while stopped
    end else if (advance) begin
      pc <= next_pc;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stall flag and stop drain

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stalled  <= 1'b0;
      stopping <= 1'b1;                        // come out of reset halted
      stopped  <= 1'b0;
      stop_ctr <= CTR_W'(`MINI_CPU_STOP_FLUSH); // one more for the rom read
    end else begin
      if (stalling)
        stalled <= 1'b1;
      else if (stall_clear)
        stalled <= 1'b0;

      if (run) begin
        stopping <= 1'b0;
        stopped  <= 1'b0;
        stop_ctr <= CTR_W'(`MINI_CPU_STOP_FLUSH - 1);
      end else begin
        if (!stalling)
          stopping <= 1'b1;  // never drop a branch mid-stall
        if (stopping && stop_ctr != '0)
          stop_ctr <= stop_ctr - 1'b1;
        if (stopping && stop_ctr == '0)
          stopped <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/instr_rom.sv
`timescale 1ns/1ps
`include "mini_cpu_config.svh"

module instr_rom (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mini_cpu_pkg::imem_load_t load,
  input  logic [31:0]              fetch_addr,
  output logic [31:0]              fetch_data
);

  localparam int IDX_W = $clog2(`MINI_CPU_IMEM_WORDS);

  logic [31:0]      mem [`MINI_CPU_IMEM_WORDS];
  logic [IDX_W-1:0] rd_idx;
  logic             in_range;

  // word addressed, byte offset dropped
  assign rd_idx   = fetch_addr[IDX_W+1:2];
  assign in_range = fetch_addr[31:2] < 30'(`MINI_CPU_IMEM_WORDS);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host load port

  // host loads only while the core is stopped, so no read/write clash
  always_ff @(posedge clk) begin
    if (load.valid)
      mem[load.addr] <= load.word;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // registered read, one cycle behind fetch_addr

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_data <= `MINI_CPU_NOP;
    end else if (in_range) begin
      fetch_data <= mem[rd_idx];
    end else begin
      fetch_data <= `MINI_CPU_NOP;  // e.g. the reset pc
    end
  end

endmodule

// File: verilog/mini_cpu_pkg.sv
package mini_cpu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction encoding

  // mem and branch classes stall fetch until the back end clears it
  typedef enum logic [1:0] {
    CLS_ALU    = 2'b00,
    CLS_MEM    = 2'b01,
    CLS_BRANCH = 2'b10,
    CLS_MISC   = 2'b11
  } instr_class_e;

  typedef enum logic [1:0] {
    ALU_ADDI = 2'b00,  // rd = ra + imm
    ALU_ADD  = 2'b01,  // rd = ra + rb
    ALU_XOR  = 2'b10,  // rd = ra ^ rb
    ALU_LUI  = 2'b11   // rd = imm << 16
  } alu_op_e;

  typedef struct packed {
    instr_class_e       cls;   // 31:30
    logic [1:0]         op;    // 29:28, meaning depends on class
    logic [2:0]         rd;    // 27:25
    logic [2:0]         ra;    // 24:22
    logic [2:0]         rb;    // 21:19
    logic [2:0]         rsvd;  // 18:16, unused
    logic signed [15:0] imm;   // 15:0
  } instr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // host side: debug commands and program load

  typedef enum logic [2:0] {
    DBG_HALT     = 3'd0,
    DBG_RESUME   = 3'd1,
    DBG_READ_PC  = 3'd2,
    DBG_WRITE_PC = 3'd3,
    DBG_READ_REG = 3'd4
  } dbg_cmd_e;

  typedef struct packed {
    dbg_cmd_e    cmd;
    logic [2:0]  reg_idx;  // read_reg only
    logic [31:0] data;     // write_pc only
  } dbg_cmd_t;

  typedef struct packed {
    logic        err;   // command refused, nothing changed
    logic [31:0] data;
  } dbg_rsp_t;

  typedef struct packed {
    logic        valid;  // one word per cycle while high
    logic [5:0]  addr;   // word address
    logic [31:0] word;
  } imem_load_t;

endpackage

// File: verilog/mini_cpu_top.sv
`timescale 1ns/1ps

module mini_cpu_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mini_cpu_pkg::imem_load_t load,
  input  logic                     dbg_req,
  input  mini_cpu_pkg::dbg_cmd_t   dbg_cmd,
  output logic                     dbg_ack,
  output mini_cpu_pkg::dbg_rsp_t   dbg_rsp
);

  mini_cpu_pkg::instr_t instr;  // fetch to execute
  logic [31:0]          pc_plus_4;
  logic [31:0]          fetch_addr;
  logic [31:0]          fetch_data;
  logic                 stall_clear;
  logic                 branch_taken;
  logic [31:0]          branch_pc;
  logic                 run;      // debug to fetch
  logic                 stopped;
  logic [31:0]          dbg_pc;
  logic                 dbg_pc_wr_en;
  logic [31:0]          dbg_pc_wr_val;
  logic [2:0]           dbg_reg_sel;
  logic [31:0]          dbg_reg_val;

  fetch_unit u_fetch (
    .clk, .rst_n, .stall_clear, .branch_taken, .branch_pc, .fetch_data, .run,
    .dbg_pc_wr_en, .dbg_pc_wr_val, .instr, .pc_plus_4, .fetch_addr, .stopped, .dbg_pc
  );

  instr_rom u_rom (
    .clk, .rst_n, .load, .fetch_addr, .fetch_data
  );

  exec_unit u_exec (
    .clk, .rst_n, .instr, .pc_plus_4, .dbg_reg_sel,
    .branch_taken, .branch_pc, .stall_clear, .dbg_reg_val
  );

  debug_ctrl u_dbg (
    .clk, .rst_n, .dbg_req, .dbg_cmd, .stopped, .dbg_pc, .dbg_reg_val,
    .dbg_ack, .dbg_rsp, .run, .dbg_pc_wr_en, .dbg_pc_wr_val, .dbg_reg_sel
  );

endmodule
